// File: rtl/axi_mem_pkg.sv
// Shared widths and the burst length type; imported by the top level and the burst walker.
package axi_mem_pkg;

  // Width of the byte address on AW and AR.
  localparam int unsigned ADDR_WIDTH = 16;

  // Width of the AXI data bus.
  // Every beat uses the full width.
  localparam int unsigned DATA_WIDTH = 64;

  // Width of the transaction ID.
  localparam int unsigned ID_WIDTH = 4;

  // Number of narrow banks behind one beat.
  // Must divide DATA_WIDTH evenly, with at least one byte per bank.
  localparam int unsigned NUM_BANKS = 4;

  // Words per bank.
  // A power of two, so the word index wraps cleanly.
  localparam int unsigned BANK_DEPTH = 64;

  // AXI burst length, encoded as beats minus one.
  typedef logic [7:0] len_t;

endpackage

// File: rtl/mem_bank_if.sv
// Per-bank request and response wires shared by the splitter, one bank and the merger.
`timescale 1ns/1ps

interface mem_bank_if #(
  parameter int unsigned DATA_WIDTH = 0,
  parameter int unsigned NUM_BANKS  = 0,
  parameter int unsigned BANK_DEPTH = 0
);

  // One bank holds one slice of a beat.
  localparam int unsigned SLICE_WIDTH = DATA_WIDTH / NUM_BANKS;
  localparam int unsigned SLICE_STRB  = SLICE_WIDTH / 8;
  localparam int unsigned IDX_WIDTH   = $clog2(BANK_DEPTH);

  // Request side, a one-cycle pulse per access.
  logic                   req;
  logic [IDX_WIDTH-1:0]   addr;
  logic [SLICE_WIDTH-1:0] wdata;
  logic [SLICE_STRB-1:0]  strb;
  logic                   we;

  // Response side, one rvalid for every req.
  logic                   rvalid;
  logic [SLICE_WIDTH-1:0] rdata;

  modport splitter (output req, addr, wdata, strb, we);
  modport bank     (input req, addr, wdata, strb, we, output rvalid, rdata);
  modport merger   (input rvalid, rdata);

endinterface

// File: rtl/axi_burst_walker.sv
// Accepts AXI AW, W and AR bursts and steps through them one full-width beat at a time.
`timescale 1ns/1ps

module axi_burst_walker import axi_mem_pkg::*; #(
  parameter int unsigned ADDR_WIDTH = 0,
  parameter int unsigned DATA_WIDTH = 0,
  parameter int unsigned ID_WIDTH   = 0
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  logic [ADDR_WIDTH-1:0]   aw_addr_i,
  input  len_t                    aw_len_i,
  input  logic [ID_WIDTH-1:0]     aw_id_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  input  logic [DATA_WIDTH-1:0]   w_data_i,
  input  logic [DATA_WIDTH/8-1:0] w_strb_i,
  input  logic                    w_last_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  input  logic [ADDR_WIDTH-1:0]   ar_addr_i,
  input  len_t                    ar_len_i,
  input  logic [ID_WIDTH-1:0]     ar_id_i,
  output logic                    beat_valid_o,
  input  logic                    beat_ready_i,
  output logic [ADDR_WIDTH-1:0]   beat_addr_o,
  output logic                    beat_we_o,
  output logic [DATA_WIDTH-1:0]   beat_wdata_o,
  output logic [DATA_WIDTH/8-1:0] beat_strb_o,
  output logic                    beat_last_o,
  output logic [ID_WIDTH-1:0]     beat_id_o,
  output logic                    busy_o
);

  // Address step per beat, always the full bus width.
  localparam int unsigned BEAT_BYTES = DATA_WIDTH / 8;

  logic                  active_q;
  logic                  last_write_q;
  logic                  is_write_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  len_t                  cnt_q;
  logic [ID_WIDTH-1:0]   id_q;
  logic                  pick_write;
  logic                  beat_fire;

  // Take a write unless a read also waits and the last burst was a write.
  // This alternates the two kinds under contention.
  assign pick_write = aw_valid_i && (!ar_valid_i || !last_write_q);
  assign aw_ready_o = !active_q && pick_write;
  assign ar_ready_o = !active_q && ar_valid_i && !pick_write;

  // Write beats also need data on W.
  assign beat_valid_o = active_q && (!is_write_q || w_valid_i);
  assign w_ready_o    = active_q && is_write_q && beat_ready_i;
  assign beat_fire    = beat_valid_o && beat_ready_i;

  assign beat_addr_o  = addr_q;
  assign beat_we_o    = is_write_q;
  assign beat_wdata_o = w_data_i;
  assign beat_strb_o  = w_strb_i;
  assign beat_id_o    = id_q;
  // Writes end on the master's WLAST, reads on the beat counter.
  assign beat_last_o  = is_write_q ? w_last_i : (cnt_q == '0);
  assign busy_o       = active_q;

  // Burst ownership and arbitration history.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q     <= 1'b0;
      last_write_q <= 1'b0;
    end else if (!active_q) begin
      if (aw_ready_o) begin
        active_q     <= 1'b1;
        last_write_q <= 1'b1;
      end else if (ar_ready_o) begin
        active_q     <= 1'b1;
        last_write_q <= 1'b0;
      end
    end else if (beat_fire && beat_last_o) begin
      active_q <= 1'b0;
    end
  end

  // Burst payload, loaded on the AW or AR handshake.
  always_ff @(posedge clk_i) begin
    if (aw_ready_o) begin
      addr_q     <= aw_addr_i;
      cnt_q      <= aw_len_i;
      id_q       <= aw_id_i;
      is_write_q <= 1'b1;
    end else if (ar_ready_o) begin
      addr_q     <= ar_addr_i;
      cnt_q      <= ar_len_i;
      id_q       <= ar_id_i;
      is_write_q <= 1'b0;
    end else if (beat_fire) begin
      // INCR only.
      addr_q <= addr_q + ADDR_WIDTH'(BEAT_BYTES);
      cnt_q  <= cnt_q - 1'b1;
    end
  end

endmodule

// File: rtl/bank_splitter.sv
// Cuts each full-width beat into per-bank requests and tells the merger which banks will answer.
`timescale 1ns/1ps

module bank_splitter #(
  parameter int unsigned ADDR_WIDTH = 0,
  parameter int unsigned DATA_WIDTH = 0,
  parameter int unsigned ID_WIDTH   = 0,
  parameter int unsigned NUM_BANKS  = 0,
  parameter int unsigned BANK_DEPTH = 0,
  parameter bit          HIDE_STRB  = 1'b0
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    beat_valid_i,
  output logic                    beat_ready_o,
  input  logic [ADDR_WIDTH-1:0]   beat_addr_i,
  input  logic                    beat_we_i,
  input  logic [DATA_WIDTH-1:0]   beat_wdata_i,
  input  logic [DATA_WIDTH/8-1:0] beat_strb_i,
  input  logic                    beat_last_i,
  input  logic [ID_WIDTH-1:0]     beat_id_i,
  input  logic                    merger_idle_i,
  output logic                    exp_valid_o,
  output logic [NUM_BANKS-1:0]    exp_mask_o,
  output logic                    exp_we_o,
  output logic                    exp_last_o,
  output logic [ID_WIDTH-1:0]     exp_id_o,
  mem_bank_if.splitter            bank_o [NUM_BANKS]
);

  localparam int unsigned SLICE_WIDTH = DATA_WIDTH / NUM_BANKS;
  localparam int unsigned SLICE_STRB  = SLICE_WIDTH / 8;
  localparam int unsigned IDX_WIDTH   = $clog2(BANK_DEPTH);
  // Byte offset bits inside one beat.
  localparam int unsigned OFFS        = $clog2(DATA_WIDTH / 8);

  logic                    issue_q;
  logic [NUM_BANKS-1:0]    req_d;
  logic [NUM_BANKS-1:0]    req_q;
  logic [IDX_WIDTH-1:0]    idx_q;
  logic [DATA_WIDTH-1:0]   wdata_q;
  logic [DATA_WIDTH/8-1:0] strb_q;
  logic                    we_q;
  logic                    last_q;
  logic [ID_WIDTH-1:0]     id_q;
  logic                    beat_fire;

  // One beat in flight.
  // The issue cycle is blocked too, since the merger only turns busy after it.
  assign beat_ready_o = merger_idle_i && !issue_q;
  assign beat_fire    = beat_valid_i && beat_ready_o;

  // Reads hit every bank.
  // Writes may skip banks whose strobe slice is empty.
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      req_d[b] = !beat_we_i || !HIDE_STRB || (|beat_strb_i[b*SLICE_STRB +: SLICE_STRB]);
    end
  end

  // Request pulse and merger notification, both one cycle long.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      issue_q <= 1'b0;
      req_q   <= '0;
    end else begin
      issue_q <= beat_fire;
      req_q   <= beat_fire ? req_d : '0;
    end
  end

  // Beat payload held for the issue cycle.
  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      idx_q   <= beat_addr_i[OFFS +: IDX_WIDTH];
      wdata_q <= beat_wdata_i;
      strb_q  <= beat_strb_i;
      we_q    <= beat_we_i;
      last_q  <= beat_last_i;
      id_q    <= beat_id_i;
    end
  end

  assign exp_valid_o = issue_q;
  assign exp_mask_o  = req_q;
  assign exp_we_o    = we_q;
  assign exp_last_o  = last_q;
  assign exp_id_o    = id_q;

  // Every bank sees the same word index.
  for (genvar g = 0; g < NUM_BANKS; g++) begin : gen_bank_req
    assign bank_o[g].req   = req_q[g];
    assign bank_o[g].addr  = idx_q;
    assign bank_o[g].wdata = wdata_q[g*SLICE_WIDTH +: SLICE_WIDTH];
    assign bank_o[g].strb  = strb_q[g*SLICE_STRB +: SLICE_STRB];
    assign bank_o[g].we    = we_q;
  end

endmodule

// File: rtl/mem_bank.sv
// One narrow on-chip storage bank with byte enables and a fixed one-cycle response.
`timescale 1ns/1ps

module mem_bank #(
  parameter int unsigned DATA_WIDTH = 0,
  parameter int unsigned NUM_BANKS  = 0,
  parameter int unsigned BANK_DEPTH = 0
) (
  input  logic     clk_i,
  input  logic     reset_i,
  mem_bank_if.bank port_io
);

  localparam int unsigned SLICE_WIDTH = DATA_WIDTH / NUM_BANKS;
  localparam int unsigned SLICE_STRB  = SLICE_WIDTH / 8;

  logic [SLICE_WIDTH-1:0] mem_q [BANK_DEPTH];
  logic                   rvalid_q;
  logic [SLICE_WIDTH-1:0] rdata_q;

  // Every access answers one cycle later, writes included.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= port_io.req;
    end
  end

  // Storage and read port.
  always_ff @(posedge clk_i) begin
    if (port_io.req) begin
      if (port_io.we) begin
        // Byte lanes with a clear strobe keep their old value.
        for (int b = 0; b < SLICE_STRB; b++) begin
          if (port_io.strb[b]) begin
            mem_q[port_io.addr][8*b +: 8] <= port_io.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[port_io.addr];
      end
    end
  end

  assign port_io.rvalid = rvalid_q;
  assign port_io.rdata  = rdata_q;

endmodule

// File: rtl/resp_merger.sv
// Gathers bank answers for one beat and presents them as an AXI R beat or B response.
`timescale 1ns/1ps

module resp_merger #(
  parameter int unsigned DATA_WIDTH = 0,
  parameter int unsigned ID_WIDTH   = 0,
  parameter int unsigned NUM_BANKS  = 0
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  exp_valid_i,
  input  logic [NUM_BANKS-1:0]  exp_mask_i,
  input  logic                  exp_we_i,
  input  logic                  exp_last_i,
  input  logic [ID_WIDTH-1:0]   exp_id_i,
  mem_bank_if.merger            bank_i [NUM_BANKS],
  output logic                  merger_idle_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output logic [DATA_WIDTH-1:0] r_data_o,
  output logic [ID_WIDTH-1:0]   r_id_o,
  output logic                  r_last_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output logic [ID_WIDTH-1:0]   b_id_o
);

  localparam int unsigned SLICE_WIDTH = DATA_WIDTH / NUM_BANKS;

  typedef enum logic [1:0] {
    IDLE,
    COLLECT,
    RESP
  } state_e;

  state_e                                 state_q;
  logic [NUM_BANKS-1:0]                   pend_q;
  logic [NUM_BANKS-1:0]                   rvalid_vec;
  logic [NUM_BANKS-1:0][SLICE_WIDTH-1:0]  rdata_vec;
  logic [NUM_BANKS-1:0][SLICE_WIDTH-1:0]  data_q;
  logic                                   we_q;
  logic                                   last_q;
  logic [ID_WIDTH-1:0]                    id_q;
  logic                                   all_done;
  logic                                   resp_fire;

  // Flatten the bank answers.
  for (genvar g = 0; g < NUM_BANKS; g++) begin : gen_bank_rsp
    assign rvalid_vec[g] = bank_i[g].rvalid;
    assign rdata_vec[g]  = bank_i[g].rdata;
  end

  // Done once every outstanding bank has answered, now or earlier.
  assign all_done  = (pend_q & ~rvalid_vec) == '0;
  assign resp_fire = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i);

  assign merger_idle_o = (state_q == IDLE);
  assign r_valid_o     = (state_q == RESP) && !we_q;
  assign b_valid_o     = (state_q == RESP) && we_q;
  assign r_data_o      = data_q;
  assign r_id_o        = id_q;
  assign r_last_o      = last_q;
  assign b_id_o        = id_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      pend_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (exp_valid_i) begin
            state_q <= COLLECT;
            pend_q  <= exp_mask_i;
          end
        end
        COLLECT: begin
          pend_q <= pend_q & ~rvalid_vec;
          if (all_done) begin
            // Inner write beats need no response.
            state_q <= (we_q && !last_q) ? IDLE : RESP;
          end
        end
        RESP: begin
          // Held here under back-pressure.
          if (resp_fire) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Beat attributes and read data slices.
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && exp_valid_i) begin
      we_q   <= exp_we_i;
      last_q <= exp_last_i;
      id_q   <= exp_id_i;
    end
    if (state_q == COLLECT) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (rvalid_vec[b]) begin
          data_q[b] <= rdata_vec[b];
        end
      end
    end
  end

endmodule

// File: rtl/axi_to_mem_top.sv
// AXI4 subordinate top level that stores INCR bursts across several narrow banks.
`timescale 1ns/1ps

module axi_to_mem_top import axi_mem_pkg::*; #(
  parameter int unsigned ADDR_WIDTH = axi_mem_pkg::ADDR_WIDTH,
  parameter int unsigned DATA_WIDTH = axi_mem_pkg::DATA_WIDTH,
  parameter int unsigned ID_WIDTH   = axi_mem_pkg::ID_WIDTH,
  parameter int unsigned NUM_BANKS  = axi_mem_pkg::NUM_BANKS,
  parameter int unsigned BANK_DEPTH = axi_mem_pkg::BANK_DEPTH,
  parameter bit          HIDE_STRB  = 1'b1
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  logic [ADDR_WIDTH-1:0]   aw_addr_i,
  input  len_t                    aw_len_i,
  input  logic [ID_WIDTH-1:0]     aw_id_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  input  logic [DATA_WIDTH-1:0]   w_data_i,
  input  logic [DATA_WIDTH/8-1:0] w_strb_i,
  input  logic                    w_last_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  input  logic [ADDR_WIDTH-1:0]   ar_addr_i,
  input  len_t                    ar_len_i,
  input  logic [ID_WIDTH-1:0]     ar_id_i,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output logic [DATA_WIDTH-1:0]   r_data_o,
  output logic [ID_WIDTH-1:0]     r_id_o,
  output logic                    r_last_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  output logic [ID_WIDTH-1:0]     b_id_o,
  output logic                    busy_o
);

  // Walker to splitter.
  logic                    beat_valid;
  logic                    beat_ready;
  logic [ADDR_WIDTH-1:0]   beat_addr;
  logic                    beat_we;
  logic [DATA_WIDTH-1:0]   beat_wdata;
  logic [DATA_WIDTH/8-1:0] beat_strb;
  logic                    beat_last;
  logic [ID_WIDTH-1:0]     beat_id;

  // Splitter to merger.
  logic                    exp_valid;
  logic [NUM_BANKS-1:0]    exp_mask;
  logic                    exp_we;
  logic                    exp_last;
  logic [ID_WIDTH-1:0]     exp_id;
  logic                    merger_idle;

  // One bus per bank.
  mem_bank_if #(
    .DATA_WIDTH (DATA_WIDTH),
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH)
  ) bank_bus [NUM_BANKS] ();

  axi_burst_walker #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH)
  ) i_walker (
    .clk_i, .reset_i,
    .aw_valid_i, .aw_ready_o, .aw_addr_i, .aw_len_i, .aw_id_i,
    .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i, .w_last_i,
    .ar_valid_i, .ar_ready_o, .ar_addr_i, .ar_len_i, .ar_id_i,
    .beat_valid_o (beat_valid),
    .beat_ready_i (beat_ready),
    .beat_addr_o  (beat_addr),
    .beat_we_o    (beat_we),
    .beat_wdata_o (beat_wdata),
    .beat_strb_o  (beat_strb),
    .beat_last_o  (beat_last),
    .beat_id_o    (beat_id),
    .busy_o
  );

  bank_splitter #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH),
    .HIDE_STRB  (HIDE_STRB)
  ) i_splitter (
    .clk_i, .reset_i,
    .beat_valid_i  (beat_valid),
    .beat_ready_o  (beat_ready),
    .beat_addr_i   (beat_addr),
    .beat_we_i     (beat_we),
    .beat_wdata_i  (beat_wdata),
    .beat_strb_i   (beat_strb),
    .beat_last_i   (beat_last),
    .beat_id_i     (beat_id),
    .merger_idle_i (merger_idle),
    .exp_valid_o   (exp_valid),
    .exp_mask_o    (exp_mask),
    .exp_we_o      (exp_we),
    .exp_last_o    (exp_last),
    .exp_id_o      (exp_id),
    .bank_o        (bank_bus)
  );

  for (genvar g = 0; g < NUM_BANKS; g++) begin : gen_bank
    mem_bank #(
      .DATA_WIDTH (DATA_WIDTH),
      .NUM_BANKS  (NUM_BANKS),
      .BANK_DEPTH (BANK_DEPTH)
    ) i_bank (
      .clk_i, .reset_i,
      .port_io (bank_bus[g])
    );
  end

  resp_merger #(
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .NUM_BANKS  (NUM_BANKS)
  ) i_merger (
    .clk_i, .reset_i,
    .exp_valid_i   (exp_valid),
    .exp_mask_i    (exp_mask),
    .exp_we_i      (exp_we),
    .exp_last_i    (exp_last),
    .exp_id_i      (exp_id),
    .bank_i        (bank_bus),
    .merger_idle_o (merger_idle),
    .r_valid_o, .r_ready_i, .r_data_o, .r_id_o, .r_last_o,
    .b_valid_o, .b_ready_i, .b_id_o
  );

endmodule

// File: sim/axi_to_mem_chk.sv
// Handshake assertions, bound into the AXI to banked memory top level.
`timescale 1ns/1ps

module axi_to_mem_chk #(
  parameter int unsigned DATA_WIDTH = 0,
  parameter int unsigned ID_WIDTH   = 0
) (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  aw_ready_i,
  input logic                  ar_ready_i,
  input logic                  r_valid_i,
  input logic                  r_ready_i,
  input logic [DATA_WIDTH-1:0] r_data_i,
  input logic                  b_valid_i,
  input logic                  b_ready_i,
  input logic [ID_WIDTH-1:0]   b_id_i,
  input logic                  busy_i
);

  int fail_count = 0;

  // R held with its data until taken.
  a_r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i))
    else begin
      fail_count++;
      $error("R dropped or changed before r_ready");
    end

  // B held with its ID until taken.
  a_b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_id_i))
    else begin
      fail_count++;
      $error("B dropped or changed before b_ready");
    end

  // One burst accepted at a time.
  a_one_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    !(aw_ready_i && ar_ready_i))
    else begin
      fail_count++;
      $error("AW and AR ready together");
    end

  a_busy_reset: assert property (@(posedge clk_i) reset_i |=> !busy_i)
    else begin
      fail_count++;
      $error("busy high after reset");
    end

endmodule

bind axi_to_mem_top axi_to_mem_chk #(
  .DATA_WIDTH (DATA_WIDTH),
  .ID_WIDTH   (ID_WIDTH)
) i_chk (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .aw_ready_i (aw_ready_o),
  .ar_ready_i (ar_ready_o),
  .r_valid_i  (r_valid_o),
  .r_ready_i  (r_ready_i),
  .r_data_i   (r_data_o),
  .b_valid_i  (b_valid_o),
  .b_ready_i  (b_ready_i),
  .b_id_i     (b_id_o),
  .busy_i     (busy_o)
);

// File: sim/axi_to_mem_tb.sv
// Directed testbench for the AXI to banked memory top level; run it with the vlog.f file list.
`timescale 1ns/1ps

module axi_to_mem_tb import axi_mem_pkg::*; ;

  localparam int BEAT_BYTES = DATA_WIDTH / 8;
  // Bytes the banks can hold before the word index wraps.
  localparam int REF_BYTES  = BANK_DEPTH * BEAT_BYTES;
  // The tests need a few hundred cycles, so this leaves a wide margin.
  localparam int MAX_CYCLES = 4000;

  logic                  clk_i;
  logic                  reset_i;
  logic                  aw_valid_i;
  logic                  aw_ready_o;
  logic [ADDR_WIDTH-1:0] aw_addr_i;
  len_t                  aw_len_i;
  logic [ID_WIDTH-1:0]   aw_id_i;
  logic                  w_valid_i;
  logic                  w_ready_o;
  logic [DATA_WIDTH-1:0] w_data_i;
  logic [BEAT_BYTES-1:0] w_strb_i;
  logic                  w_last_i;
  logic                  ar_valid_i;
  logic                  ar_ready_o;
  logic [ADDR_WIDTH-1:0] ar_addr_i;
  len_t                  ar_len_i;
  logic [ID_WIDTH-1:0]   ar_id_i;
  logic                  r_valid_o;
  logic                  r_ready_i;
  logic [DATA_WIDTH-1:0] r_data_o;
  logic [ID_WIDTH-1:0]   r_id_o;
  logic                  r_last_o;
  logic                  b_valid_o;
  logic                  b_ready_i;
  logic [ID_WIDTH-1:0]   b_id_o;
  logic                  busy_o;

  // Reference memory, one entry per byte.
  logic [7:0]            ref_mem [REF_BYTES];
  // Write beats staged by each test before a burst.
  logic [DATA_WIDTH-1:0] wr_data [16];
  logic [BEAT_BYTES-1:0] wr_strb [16];

  integer seed = 32'h855;
  int     errors = 0;
  int     tests_run = 0;
  int     cycles = 0;

  axi_to_mem_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH),
    .HIDE_STRB  (1'b1)
  ) uut (.*);

  always #2 clk_i = ~clk_i;

  // Run limit.
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", MAX_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic close_test(input string name, input int err_start);
    tests_run++;
    $display("done %s, %0d errors", name, errors - err_start);
  endtask

  // Expected beat assembled from the reference bytes.
  function automatic logic [DATA_WIDTH-1:0] expected_word(input int addr);
    logic [DATA_WIDTH-1:0] w;
    for (int i = 0; i < BEAT_BYTES; i++) begin
      w[8*i +: 8] = ref_mem[(addr + i) % REF_BYTES];
    end
    return w;
  endfunction

  // AW, then the staged W beats, then B.
  task automatic write_burst(input logic [ADDR_WIDTH-1:0] addr, input int len,
                             input logic [ID_WIDTH-1:0] id);
    int base;
    base = int'(addr);
    @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= addr;
    aw_len_i   <= len_t'(len - 1);
    aw_id_i    <= id;
    do @(negedge clk_i); while (!aw_ready_o);
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
    for (int beat = 0; beat < len; beat++) begin
      w_valid_i <= 1'b1;
      w_data_i  <= wr_data[beat];
      w_strb_i  <= wr_strb[beat];
      w_last_i  <= (beat == len - 1);
      do @(negedge clk_i); while (!w_ready_o);
      // The burst is still open until its last beat is taken.
      if (busy_o !== 1'b1) begin
        report_mismatch("busy_o", busy_o, 1'b1);
      end
      // Strobe rule, only enabled bytes change.
      for (int i = 0; i < BEAT_BYTES; i++) begin
        if (wr_strb[beat][i]) begin
          ref_mem[(base + beat * BEAT_BYTES + i) % REF_BYTES] = wr_data[beat][8*i +: 8];
        end
      end
      @(posedge clk_i);
    end
    w_valid_i <= 1'b0;
    w_last_i  <= 1'b0;
    // B waits one cycle under back-pressure before it is taken.
    do @(negedge clk_i); while (!b_valid_o);
    if (b_id_o !== id) begin
      report_mismatch("b_id_o", b_id_o, id);
    end
    @(posedge clk_i);
    b_ready_i <= 1'b1;
    @(posedge clk_i);
    b_ready_i <= 1'b0;
  endtask

  // AR, then every R beat checked against the reference memory.
  task automatic read_burst(input logic [ADDR_WIDTH-1:0] addr, input int len,
                            input logic [ID_WIDTH-1:0] id, input bit rand_ready);
    int                    beat;
    int                    rnd;
    logic [DATA_WIDTH-1:0] exp_data;
    beat = 0;
    @(posedge clk_i);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= addr;
    ar_len_i   <= len_t'(len - 1);
    ar_id_i    <= id;
    do @(negedge clk_i); while (!ar_ready_o);
    @(posedge clk_i);
    ar_valid_i <= 1'b0;
    while (beat < len) begin
      rnd = $random(seed);
      r_ready_i <= rand_ready ? rnd[0] : 1'b1;
      @(negedge clk_i);
      if (r_valid_o && r_ready_i) begin
        exp_data = expected_word(int'(addr) + beat * BEAT_BYTES);
        if (r_data_o !== exp_data) begin
          report_mismatch("r_data_o", r_data_o, exp_data);
        end
        if (r_id_o !== id) begin
          report_mismatch("r_id_o", r_id_o, id);
        end
        if (r_last_o !== (beat == len - 1)) begin
          report_mismatch("r_last_o", r_last_o, beat == len - 1);
        end
        beat++;
      end
      @(posedge clk_i);
    end
    r_ready_i <= 1'b0;
    @(negedge clk_i);
    if (r_valid_o) begin
      $display("Extra R beat at %0t after the last beat of the burst", $time);
      errors++;
    end
  endtask

  task automatic test_single;
    int e0;
    e0 = errors;
    wr_data[0] = 64'h0123_4567_89ab_cdef;
    wr_strb[0] = '1;
    write_burst(16'h0040, 1, 4'h3);
    read_burst(16'h0040, 1, 4'h5, 1'b0);
    close_test("single beat write and read", e0);
  endtask

  task automatic test_burst4;
    int e0;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      wr_data[i] = {$random(seed), $random(seed)};
      wr_strb[i] = '1;
    end
    write_burst(16'h0100, 4, 4'h1);
    read_burst(16'h0100, 4, 4'h2, 1'b0);
    close_test("4-beat burst", e0);
  endtask

  task automatic test_partial;
    int e0;
    e0 = errors;
    // Bank 1 slice has no strobe, the second beat none at all.
    wr_data[0] = 64'hfeed_face_dead_beef;
    wr_strb[0] = 8'b1011_0001;
    wr_data[1] = 64'h1111_2222_3333_4444;
    wr_strb[1] = 8'h00;
    write_burst(16'h0100, 2, 4'h4);
    read_burst(16'h0100, 2, 4'h4, 1'b0);
    close_test("partial strobe", e0);
  endtask

  task automatic test_random_ready;
    int e0;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      wr_data[i] = {$random(seed), $random(seed)};
      wr_strb[i] = '1;
    end
    write_burst(16'h0080, 8, 4'h8);
    read_burst(16'h0080, 8, 4'h9, 1'b1);
    close_test("random r_ready", e0);
  endtask

  task automatic test_both;
    int e0;
    e0 = errors;
    wr_data[0] = 64'haaaa_5555_0f0f_f0f0;
    wr_data[1] = 64'h7777_8888_9999_0000;
    wr_strb[0] = '1;
    wr_strb[1] = '1;
    // Both tasks raise AW and AR on the same edge.
    fork
      write_burst(16'h0180, 2, 4'h6);
      read_burst(16'h0100, 4, 4'h7, 1'b0);
    join
    @(negedge clk_i);
    if (busy_o !== 1'b0) begin
      report_mismatch("busy_o", busy_o, 1'b0);
    end
    close_test("AW and AR together", e0);
  endtask

  initial begin
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_id_i    = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    ar_id_i    = '0;
    r_ready_i  = 1'b0;
    b_ready_i  = 1'b0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;

    test_single();
    test_burst4();
    test_partial();
    test_random_ready();
    test_both();

    // Assertion failures from the bound checker count as errors.
    errors = errors + uut.i_chk.fail_count;
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
rtl/axi_mem_pkg.sv
rtl/mem_bank_if.sv
rtl/axi_burst_walker.sv
rtl/bank_splitter.sv
rtl/mem_bank.sv
rtl/resp_merger.sv
rtl/axi_to_mem_top.sv
sim/axi_to_mem_chk.sv
sim/axi_to_mem_tb.sv
